/* icache_req_pkg.sv */
/*
 * Shared widths, address split constants and channel number
 * Start-up and settle counts, request id and burst type definitions
 */
`default_nettype none

package icache_req_pkg;

	// ========================================================================
	// Address and id widths
	// ========================================================================

	localparam int ADDR_W = 32;
	localparam int ASID_W = 8;

	// Snoop source channel field width
	localparam int CID_W = 3;

	// Width of the start-up and settle down-counter
	localparam int TIMER_W = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ASID_W-1:0] asid_t;

	// ========================================================================
	// Line geometry
	// ========================================================================

	// A line is 64 bytes, fetched as four 16-byte beats
	localparam int LINE_LO_BIT = 6;
	localparam int BEAT_BYTES = 16;
	localparam int BEATS = 4;

	// Cache index bits compared against a snoop address
	localparam int SNOOP_HI_BIT = 13;

	// Beat virtual addresses kept for the fetch stage, one per line tag and beat
	localparam int VTAG_ENTRIES = 16;

	// ========================================================================
	// Channel and timing constants
	// ========================================================================

	localparam logic [CID_W-1:0] CHANNEL_ID = 3'd2;

	// Each channel waits a different number of cycles after reset
	localparam logic [TIMER_W-1:0] STARTUP_CYCLES = TIMER_W'(CHANNEL_ID * 4 + 1);

	// Cycles the cache needs after ack before the next miss
	localparam logic [TIMER_W-1:0] SETTLE_CYCLES = 4'd2;

	// Transaction id, upper half is the line tag and lower half the beat
	typedef struct packed {
		logic [1:0] tag;
		logic [1:0] beat;
	} tranid_t;

	// Burst type seen on the fetch bus
	typedef enum logic [1:0] {
		CLASSIC = 2'd0,
		FIXED = 2'd1,
		EOB = 2'd2
	} cti_t;

	// Clears the byte offset within the line
	function automatic addr_t line_align(addr_t adr);
		return {adr[ADDR_W-1:LINE_LO_BIT], {LINE_LO_BIT{1'b0}}};
	endfunction

endpackage

`default_nettype wire

/* icache_req_timer.sv */
/*
 * Down-counter for the start-up stagger and the post-ack settle delay
 */
`timescale 1ns/100ps
`default_nettype none

module icache_req_timer
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic [icache_req_pkg::TIMER_W-1:0] count,
	output logic done
);

	logic [icache_req_pkg::TIMER_W-1:0] cnt;

	// Reset loads the start-up stagger directly
	// The state machine only starts the counter for the settle delay
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt <= icache_req_pkg::STARTUP_CYCLES;
		end
		else if (start)
		begin
			cnt <= count;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
	end

	// A load in the current cycle hides a zero count
	// So done rises exactly count cycles after the start edge
	assign done = (cnt == '0) && !start;

	// The state machine may only restart an expired count
	// A restart while counting would cut the start-up or settle short
	a_start_when_idle : assert property (
		@(posedge clk) disable iff (rst)
		start |-> (cnt == '0)
	);

endmodule

`default_nettype wire

/* icache_line_addr.sv */
/*
 * Line address holder for the miss being fetched
 * Captures line-aligned addresses, steps one beat at a time, compares snoops
 */
`timescale 1ns/100ps
`default_nettype none

module icache_line_addr
(
	input wire logic clk,
	input wire logic rst,
	input wire logic capture,
	input wire logic step,
	input wire icache_req_pkg::addr_t miss_vadr,
	input wire icache_req_pkg::addr_t miss_padr,
	input wire icache_req_pkg::asid_t miss_asid,
	input wire logic snoop_v,
	input wire icache_req_pkg::addr_t snoop_adr,
	input wire logic [icache_req_pkg::CID_W-1:0] snoop_cid,
	output icache_req_pkg::addr_t line_vadr,
	output icache_req_pkg::addr_t line_padr,
	output icache_req_pkg::asid_t line_asid,
	output logic snoop_hit
);

	// ========================================================================
	// Address registers
	// ========================================================================

	// These registers drive the request address lines directly
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			line_vadr <= '0;
			line_padr <= '0;
			line_asid <= '0;
		end
		else if (capture)
		begin
			// Every fill starts at the first byte of the line
			line_vadr <= icache_req_pkg::line_align(miss_vadr);
			line_padr <= icache_req_pkg::line_align(miss_padr);
			line_asid <= miss_asid;
		end
		else if (step)
		begin
			// Advance both addresses to the next beat of the same line
			line_vadr <= line_vadr + icache_req_pkg::ADDR_W'(icache_req_pkg::BEAT_BYTES);
			line_padr <= line_padr + icache_req_pkg::ADDR_W'(icache_req_pkg::BEAT_BYTES);
		end
	end

	// ========================================================================
	// Snoop compare
	// ========================================================================

	// Only the cache index is compared since a hit there may alias the line in flight
	// A snoop raised by this channel itself never aborts its own fill
	assign snoop_hit = snoop_v
		&& (snoop_cid != icache_req_pkg::CHANNEL_ID)
		&& (snoop_adr[icache_req_pkg::SNOOP_HI_BIT:icache_req_pkg::LINE_LO_BIT]
			== line_padr[icache_req_pkg::SNOOP_HI_BIT:icache_req_pkg::LINE_LO_BIT]);

	// Beats are whole 16-byte units on the bus
	// Capture aligns and step adds a multiple of the beat size
	a_beat_aligned : assert property (
		@(posedge clk) disable iff (rst)
		(line_vadr[$clog2(icache_req_pkg::BEAT_BYTES)-1:0] == '0)
		&& (line_padr[$clog2(icache_req_pkg::BEAT_BYTES)-1:0] == '0)
	);

endmodule

`default_nettype wire

/* icache_vtag_table.sv */
/*
 * Table of beat virtual addresses indexed by line tag and beat number
 * All entries are visible at once to the fetch stage
 */
`timescale 1ns/100ps
`default_nettype none

module icache_vtag_table
(
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire icache_req_pkg::tranid_t widx,
	input wire icache_req_pkg::addr_t wdata,
	output icache_req_pkg::addr_t [icache_req_pkg::VTAG_ENTRIES-1:0] vtags
);

	// ========================================================================
	// Entry storage
	// ========================================================================

	// The response path matches returning data by transaction id
	// and looks up the virtual address of the beat here
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vtags <= '0;
		end
		else if (we)
		begin
			// One entry per taken beat
			// tag selects the group of four and beat the slot in it
			vtags[{widx.tag, widx.beat}] <= wdata;
		end
	end

	// An unknown index here would smear a write across the whole table
	// The index comes from the line tag and beat counter in the state machine
	a_widx_known : assert property (
		@(posedge clk) disable iff (rst)
		we |-> !$isunknown(widx)
	);

endmodule

`default_nettype wire

/* icache_miss_fsm.sv */
/*
 * Miss request state machine
 * Sequences start-up, idle, four beats with gaps, ack wait and settle
 * Keeps the line tag and beat counters and drives the fetch bus strobes
 */
`timescale 1ns/100ps
`default_nettype none

module icache_miss_fsm
(
	input wire logic clk,
	input wire logic rst,
	input wire logic hit,
	input wire logic tlb_v,
	input wire logic full,
	input wire logic ack,
	input wire logic timer_done,
	input wire logic snoop_hit,
	input wire icache_req_pkg::addr_t line_vadr,
	input wire icache_req_pkg::addr_t line_padr,
	input wire icache_req_pkg::asid_t line_asid,
	output logic timer_start,
	output logic [icache_req_pkg::TIMER_W-1:0] timer_count,
	output logic capture,
	output logic step,
	output logic tag_we,
	output icache_req_pkg::tranid_t tag_idx,
	output logic req_cyc,
	output logic req_stb,
	output icache_req_pkg::cti_t req_cti,
	output icache_req_pkg::tranid_t req_tranid,
	output icache_req_pkg::addr_t req_vadr,
	output icache_req_pkg::addr_t req_padr,
	output icache_req_pkg::asid_t req_asid
);

	typedef enum logic [2:0] {
		STARTUP,
		IDLE,
		BEAT,
		GAP,
		WAIT_ACK,
		SETTLE
	} state_t;

	state_t state;
	logic [1:0] beat;
	logic [1:0] line_tag;
	logic miss;
	logic accept;
	logic taken;
	logic last_beat;
	logic abort;

	// ========================================================================
	// Decode
	// ========================================================================

	assign miss = !hit && tlb_v;

	// The last start-up cycle already samples a miss, like idle does
	assign accept = miss
		&& ((state == IDLE) || ((state == STARTUP) && timer_done));

	// A beat leaves the bus when it is strobed and not stalled
	assign taken = (state == BEAT) && !full;
	assign last_beat = (beat == 2'(icache_req_pkg::BEATS - 1));

	// Snoops only matter while a line is being fetched or settled
	assign abort = snoop_hit && (state != STARTUP) && (state != IDLE);

	// The holder loads the aligned miss on the accepting edge
	assign capture = accept;

	// The last beat does not step, so the held line keeps its snoop index
	// until the fill is finished
	assign step = taken && !last_beat;

	// Each taken beat records its virtual address for the response path
	assign tag_we = taken;
	assign tag_idx = {line_tag, beat};

	// Settle state exit adds one cycle to the loaded count
	assign timer_start = (state == WAIT_ACK) && ack && !abort;
	assign timer_count = icache_req_pkg::SETTLE_CYCLES - 1'b1;

	// Address lines come straight from the holder registers,
	// which already hold the current beat
	assign req_vadr = line_vadr;
	assign req_padr = line_padr;
	assign req_asid = line_asid;

	// ========================================================================
	// State register and bus strobes
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= STARTUP;
			beat <= 2'd0;
			line_tag <= 2'd0;
			req_cyc <= 1'b0;
			req_stb <= 1'b0;
			req_cti <= icache_req_pkg::CLASSIC;
			req_tranid <= '0;
		end
		else if (abort)
		begin
			// Drop the bus and forget the line, the tag is reused
			state <= IDLE;
			req_cyc <= 1'b0;
			req_stb <= 1'b0;
			req_cti <= icache_req_pkg::CLASSIC;
		end
		else
		begin
			case (state)
				STARTUP, IDLE:
				begin
					if (accept)
					begin
						state <= BEAT;
						beat <= 2'd0;
						req_cyc <= 1'b1;
						req_stb <= 1'b1;
						req_cti <= icache_req_pkg::FIXED;
						req_tranid <= {line_tag, 2'd0};
					end
					else if (timer_done)
					begin
						state <= IDLE;
					end
				end
				BEAT:
				begin
					// A stall holds every request output as it is
					if (!full)
					begin
						req_cyc <= 1'b0;
						req_stb <= 1'b0;
						if (last_beat)
						begin
							state <= WAIT_ACK;
							req_cti <= icache_req_pkg::CLASSIC;
						end
						else
						begin
							state <= GAP;
							beat <= beat + 2'd1;
						end
					end
				end
				GAP:
				begin
					// One idle bus cycle, then the next beat goes out
					state <= BEAT;
					req_cyc <= 1'b1;
					req_stb <= 1'b1;
					req_tranid <= {line_tag, beat};
					if (last_beat)
						req_cti <= icache_req_pkg::EOB;
					else
						req_cti <= icache_req_pkg::FIXED;
				end
				WAIT_ACK:
				begin
					if (ack)
						state <= SETTLE;
				end
				SETTLE:
				begin
					if (timer_done)
					begin
						state <= IDLE;
						// Tag 0 is only used by the first line after reset
						if (line_tag == 2'd3)
							line_tag <= 2'd1;
						else
							line_tag <= line_tag + 2'd1;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// The bus strobe must never show outside a beat, including after an abort
	a_stb_only_in_beat : assert property (
		@(posedge clk) disable iff (rst)
		req_stb |-> (state == BEAT)
	);

	// End of burst marks beat 3 and nothing else
	a_eob_on_last : assert property (
		@(posedge clk) disable iff (rst)
		req_stb |-> ((req_cti == icache_req_pkg::EOB) == (req_tranid.beat == 2'd3))
	);

endmodule

`default_nettype wire

/* icache_req_top.sv */
/*
 * Instruction cache miss request generator top level
 * Connects the state machine, timer, line address holder and tag table
 */
`timescale 1ns/100ps
`default_nettype none

module icache_req_top
(
	input wire logic clk,
	input wire logic rst,
	input wire logic hit,
	input wire logic tlb_v,
	input wire icache_req_pkg::addr_t miss_vadr,
	input wire icache_req_pkg::addr_t miss_padr,
	input wire icache_req_pkg::asid_t miss_asid,
	input wire logic full,
	input wire logic ack,
	input wire logic snoop_v,
	input wire icache_req_pkg::addr_t snoop_adr,
	input wire logic [icache_req_pkg::CID_W-1:0] snoop_cid,
	output logic req_cyc,
	output logic req_stb,
	output icache_req_pkg::cti_t req_cti,
	output icache_req_pkg::tranid_t req_tranid,
	output icache_req_pkg::addr_t req_vadr,
	output icache_req_pkg::addr_t req_padr,
	output icache_req_pkg::asid_t req_asid,
	output icache_req_pkg::addr_t [icache_req_pkg::VTAG_ENTRIES-1:0] vtags
);

	logic timer_start;
	logic [icache_req_pkg::TIMER_W-1:0] timer_count;
	logic timer_done;
	logic capture;
	logic step;
	logic snoop_hit;
	logic tag_we;
	icache_req_pkg::tranid_t tag_idx;
	icache_req_pkg::addr_t line_vadr;
	icache_req_pkg::addr_t line_padr;
	icache_req_pkg::asid_t line_asid;

	icache_miss_fsm icache_miss_fsm_inst (
		.clk(clk), .rst(rst), .hit(hit), .tlb_v(tlb_v), .full(full), .ack(ack),
		.timer_done(timer_done), .snoop_hit(snoop_hit),
		.line_vadr(line_vadr), .line_padr(line_padr), .line_asid(line_asid),
		.timer_start(timer_start), .timer_count(timer_count),
		.capture(capture), .step(step), .tag_we(tag_we), .tag_idx(tag_idx),
		.req_cyc(req_cyc), .req_stb(req_stb), .req_cti(req_cti),
		.req_tranid(req_tranid), .req_vadr(req_vadr), .req_padr(req_padr),
		.req_asid(req_asid)
	);

	// Start-up stagger comes from reset, settle from the state machine
	icache_req_timer icache_req_timer_inst (
		.clk(clk), .rst(rst), .start(timer_start), .count(timer_count),
		.done(timer_done)
	);

	icache_line_addr icache_line_addr_inst (
		.clk(clk), .rst(rst), .capture(capture), .step(step),
		.miss_vadr(miss_vadr), .miss_padr(miss_padr), .miss_asid(miss_asid),
		.snoop_v(snoop_v), .snoop_adr(snoop_adr), .snoop_cid(snoop_cid),
		.line_vadr(line_vadr), .line_padr(line_padr), .line_asid(line_asid),
		.snoop_hit(snoop_hit)
	);

	// The table records the holder address of the beat being taken
	icache_vtag_table icache_vtag_table_inst (
		.clk(clk), .rst(rst), .we(tag_we), .widx(tag_idx), .wdata(line_vadr),
		.vtags(vtags)
	);

endmodule

`default_nettype wire

/* tb_icache_req.sv */
/*
 * Testbench for the instruction cache miss request generator
 * Random misses, stalls, acks and snoops checked against a reference model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_icache_req;

	localparam int SEED = 25494;
	localparam int RANDOM_LINES = 60;
	localparam int ABORT_LINES = 4;
	localparam int OWN_LINES = 4;
	localparam int TOTAL_LINES = 1 + RANDOM_LINES + 2 * ABORT_LINES + OWN_LINES;
	localparam int TIMEOUT = TOTAL_LINES * 60 + int'(icache_req_pkg::STARTUP_CYCLES);

	// Snoop kinds driven during a line
	localparam int SNP_NONE = 0;
	localparam int SNP_ABORT = 1;
	localparam int SNP_OWN = 2;
	localparam int SNP_MISS = 3;

	logic clk;
	logic rst;
	logic hit;
	logic tlb_v;
	icache_req_pkg::addr_t miss_vadr;
	icache_req_pkg::addr_t miss_padr;
	icache_req_pkg::asid_t miss_asid;
	logic full;
	logic ack;
	logic snoop_v;
	icache_req_pkg::addr_t snoop_adr;
	logic [icache_req_pkg::CID_W-1:0] snoop_cid;
	logic req_cyc;
	logic req_stb;
	icache_req_pkg::cti_t req_cti;
	icache_req_pkg::tranid_t req_tranid;
	icache_req_pkg::addr_t req_vadr;
	icache_req_pkg::addr_t req_padr;
	icache_req_pkg::asid_t req_asid;
	icache_req_pkg::addr_t [icache_req_pkg::VTAG_ENTRIES-1:0] vtags;

	// Reference model keeps the expected line tag and a copy of the tag table
	logic [1:0] exp_tag;
	icache_req_pkg::addr_t model_vtags [icache_req_pkg::VTAG_ENTRIES];

	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int lines_done = 0;
	int lines_aborted = 0;

	icache_req_top icache_req_top_inst (
		.clk(clk), .rst(rst), .hit(hit), .tlb_v(tlb_v),
		.miss_vadr(miss_vadr), .miss_padr(miss_padr), .miss_asid(miss_asid),
		.full(full), .ack(ack),
		.snoop_v(snoop_v), .snoop_adr(snoop_adr), .snoop_cid(snoop_cid),
		.req_cyc(req_cyc), .req_stb(req_stb), .req_cti(req_cti),
		.req_tranid(req_tranid), .req_vadr(req_vadr), .req_padr(req_padr),
		.req_asid(req_asid), .vtags(vtags)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends a hung run after about 60 cycles per line plus the start-up stagger
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT)
		begin
			$display("Timeout: no result after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_strobe(input string name, input logic got, input logic exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_cti(input icache_req_pkg::cti_t exp);
		checks = checks + 1;
		if (req_cti !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH req_cti got %h expected %h at %0t", req_cti, exp, $time);
		end
	endtask

	// Compares all request fields of one beat but not the strobes
	task automatic check_beat(
		input icache_req_pkg::tranid_t exp_tid,
		input icache_req_pkg::addr_t exp_vadr,
		input icache_req_pkg::addr_t exp_padr,
		input icache_req_pkg::asid_t exp_asid,
		input icache_req_pkg::cti_t exp_cti
	);
		checks = checks + 4;
		if (req_tranid !== exp_tid)
		begin
			errors = errors + 1;
			$display("MISMATCH req_tranid got %h expected %h", req_tranid, exp_tid);
		end
		if (req_vadr !== exp_vadr)
		begin
			errors = errors + 1;
			$display("MISMATCH req_vadr got %h expected %h", req_vadr, exp_vadr);
		end
		if (req_padr !== exp_padr)
		begin
			errors = errors + 1;
			$display("MISMATCH req_padr got %h expected %h", req_padr, exp_padr);
		end
		if (req_asid !== exp_asid)
		begin
			errors = errors + 1;
			$display("MISMATCH req_asid got %h expected %h", req_asid, exp_asid);
		end
		check_cti(exp_cti);
	endtask

	task automatic check_vtag(input int idx, input icache_req_pkg::addr_t exp);
		checks = checks + 1;
		if (vtags[idx] !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH vtags[%0d] got %h expected %h", idx, vtags[idx], exp);
		end
	endtask

	task automatic check_table();
		for (int i = 0; i < icache_req_pkg::VTAG_ENTRIES; i++)
			check_vtag(i, model_vtags[i]);
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	// Any of the three hit and TLB combinations that are not a miss
	task automatic drive_no_miss();
		int pick;
		pick = $urandom % 3;
		hit = (pick != 2);
		tlb_v = (pick == 0);
		miss_vadr = $urandom;
		miss_padr = $urandom;
		miss_asid = 8'($urandom);
	endtask

	task automatic drive_snoop(input int mode, input icache_req_pkg::addr_t line_p);
		icache_req_pkg::addr_t adr;
		logic [icache_req_pkg::CID_W-1:0] cid;
		int bitpos;
		adr = $urandom;
		adr[icache_req_pkg::SNOOP_HI_BIT:icache_req_pkg::LINE_LO_BIT] =
			line_p[icache_req_pkg::SNOOP_HI_BIT:icache_req_pkg::LINE_LO_BIT];
		// One flipped index bit is enough to miss the line in flight
		if (mode == SNP_MISS)
		begin
			bitpos = icache_req_pkg::LINE_LO_BIT
				+ $urandom % (icache_req_pkg::SNOOP_HI_BIT - icache_req_pkg::LINE_LO_BIT + 1);
			adr[bitpos] = ~adr[bitpos];
		end
		if (mode == SNP_OWN)
			cid = icache_req_pkg::CHANNEL_ID;
		else
		begin
			cid = 3'($urandom);
			if (cid == icache_req_pkg::CHANNEL_ID)
				cid = cid + 3'd1;
		end
		snoop_v = 1'b1;
		snoop_adr = adr;
		snoop_cid = cid;
	endtask

	// One line fill from the miss to the end of settle, or to an abort
	// Called at a falling edge with the block idle or still in start-up
	task automatic run_line(input int pre_wait, input int mode);
		icache_req_pkg::addr_t line_v;
		icache_req_pkg::addr_t line_p;
		icache_req_pkg::addr_t beat_v;
		icache_req_pkg::asid_t asid;
		icache_req_pkg::tranid_t tid;
		icache_req_pkg::cti_t cti;
		int b;
		int snoop_beat;
		int wait_ack;
		logic aborted;
		logic snooped;
		logic stalled;
		hit = 1'b0;
		tlb_v = 1'b1;
		miss_vadr = $urandom;
		miss_padr = $urandom;
		miss_asid = 8'($urandom);
		line_v = (miss_vadr >> icache_req_pkg::LINE_LO_BIT) << icache_req_pkg::LINE_LO_BIT;
		line_p = (miss_padr >> icache_req_pkg::LINE_LO_BIT) << icache_req_pkg::LINE_LO_BIT;
		asid = miss_asid;
		snoop_beat = (mode == SNP_NONE) ? -1 : int'($urandom % icache_req_pkg::BEATS);
		repeat (pre_wait)
		begin
			@(negedge clk);
			check_strobe("req_stb", req_stb, 1'b0);
		end
		@(negedge clk);
		// Later miss inputs must not disturb the captured line
		drive_no_miss();
		b = 0;
		aborted = 1'b0;
		while ((b < icache_req_pkg::BEATS) && !aborted)
		begin
			beat_v = line_v + icache_req_pkg::addr_t'(b * icache_req_pkg::BEAT_BYTES);
			tid.tag = exp_tag;
			tid.beat = 2'(b);
			cti = (b == icache_req_pkg::BEATS - 1) ? icache_req_pkg::EOB : icache_req_pkg::FIXED;
			check_strobe("req_stb", req_stb, 1'b1);
			check_strobe("req_cyc", req_cyc, 1'b1);
			check_beat(tid, beat_v,
				line_p + icache_req_pkg::addr_t'(b * icache_req_pkg::BEAT_BYTES), asid, cti);
			snooped = (b == snoop_beat);
			if (snooped)
			begin
				// The beat is stalled so the snoop edge takes nothing
				drive_snoop(mode, line_p);
				full = 1'b1;
				snoop_beat = -1;
			end
			else
				full = ($urandom % 10) < 3;
			stalled = full;
			@(negedge clk);
			snoop_v = 1'b0;
			if (snooped && (mode == SNP_ABORT))
			begin
				check_strobe("req_stb", req_stb, 1'b0);
				check_strobe("req_cyc", req_cyc, 1'b0);
				check_cti(icache_req_pkg::CLASSIC);
				check_vtag(int'({exp_tag, 2'(b)}), model_vtags[{exp_tag, 2'(b)}]);
				aborted = 1'b1;
			end
			else if (!stalled)
			begin
				// The edge just passed took the beat and one quiet cycle follows
				model_vtags[{exp_tag, 2'(b)}] = beat_v;
				check_strobe("req_stb", req_stb, 1'b0);
				check_strobe("req_cyc", req_cyc, 1'b0);
				check_vtag(int'({exp_tag, 2'(b)}), beat_v);
				b = b + 1;
				if (b < icache_req_pkg::BEATS)
					@(negedge clk);
			end
		end
		if (aborted)
			lines_aborted = lines_aborted + 1;
		else
		begin
			wait_ack = 1 + $urandom % 8;
			repeat (wait_ack - 1)
			begin
				@(negedge clk);
				check_strobe("req_stb", req_stb, 1'b0);
			end
			ack = 1'b1;
			// Settle takes its cycles and one more edge returns to idle
			repeat (int'(icache_req_pkg::SETTLE_CYCLES) + 1)
			begin
				@(negedge clk);
				ack = 1'b0;
				check_strobe("req_stb", req_stb, 1'b0);
			end
			// Tag 0 is used once after reset, then 1, 2, 3 repeat
			exp_tag = (exp_tag == 2'd3) ? 2'd1 : exp_tag + 2'd1;
			lines_done = lines_done + 1;
		end
	endtask

	task automatic end_test(input string name, input int chk0, input int err0);
		if (errors == err0)
			$display("%s: ok, %0d checks", name, checks - chk0);
		else
			$display("%s: %0d errors in %0d checks", name, errors - err0, checks - chk0);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		int chk0;
		int err0;
		int gap;
		int r;
		int mode;
		void'($urandom(SEED));
		rst = 1'b1;
		hit = 1'b1;
		tlb_v = 1'b0;
		miss_vadr = '0;
		miss_padr = '0;
		miss_asid = '0;
		full = 1'b0;
		ack = 1'b0;
		snoop_v = 1'b0;
		snoop_adr = '0;
		snoop_cid = '0;
		exp_tag = 2'd0;
		for (int i = 0; i < icache_req_pkg::VTAG_ENTRIES; i++)
			model_vtags[i] = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// Reset values, then a miss held through the start-up stagger
		chk0 = checks;
		err0 = errors;
		check_strobe("req_stb", req_stb, 1'b0);
		check_strobe("req_cyc", req_cyc, 1'b0);
		check_cti(icache_req_pkg::CLASSIC);
		check_table();
		run_line(int'(icache_req_pkg::STARTUP_CYCLES), SNP_NONE);
		end_test("reset and start-up", chk0, err0);

		chk0 = checks;
		err0 = errors;
		for (int n = 0; n < RANDOM_LINES; n++)
		begin
			gap = $urandom % 3;
			repeat (gap)
			begin
				drive_no_miss();
				@(negedge clk);
				check_strobe("req_stb", req_stb, 1'b0);
			end
			r = $urandom % 10;
			if (r == 0)
				mode = SNP_ABORT;
			else if (r == 1)
				mode = SNP_OWN;
			else if (r == 2)
				mode = SNP_MISS;
			else
				mode = SNP_NONE;
			run_line(0, mode);
		end
		check_table();
		end_test("random lines", chk0, err0);

		// The line after an abort must reuse the same tag
		chk0 = checks;
		err0 = errors;
		for (int n = 0; n < ABORT_LINES; n++)
		begin
			run_line(0, SNP_ABORT);
			run_line(0, SNP_NONE);
		end
		end_test("snoop abort", chk0, err0);

		chk0 = checks;
		err0 = errors;
		for (int n = 0; n < OWN_LINES; n++)
			run_line(0, SNP_OWN);
		check_table();
		end_test("own channel snoop", chk0, err0);

		$display("checks %0d, errors %0d, lines %0d, aborted %0d",
			checks, errors, lines_done, lines_aborted);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
icache_req_pkg.sv
icache_req_timer.sv
icache_line_addr.sv
icache_vtag_table.sv
icache_miss_fsm.sv
icache_req_top.sv
tb_icache_req.sv

/* Makefile */
# Verilator build and run for the icache miss request generator

VERILATOR ?= verilator
TOP ?= tb_icache_req
LOG ?= sim.log
FLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell cat sim.f)
BIN := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(FLAGS) -f sim.f --top-module $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
